// File: Makefile
SIM      = verilator
FLAGS    = --binary -j 0
TOP      = invadersTb
FILELIST = invaders.f
BUILDDIR = obj_dir
LOG      = sim.log

BIN      = $(BUILDDIR)/V$(TOP)
SOURCES  = $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BUILDDIR)/V%: $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $* -f $(FILELIST) --Mdir $(BUILDDIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)

// File: invaders.f
source/videoPkg.sv
source/gamePkg.sv
source/pixelBus.sv
source/rasterScan.sv
source/rectSprite.sv
source/playerControl.sv
source/monsterControl.sv
source/hitDetection.sv
source/videoMixer.sv
source/invadersTop.sv
tests/invadersTb.sv

// File: source/gamePkg.sv
`default_nettype none

package gamePkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Objects and hit vector layout
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int unsigned objCount = 3;
    localparam int unsigned objPlayer = 0;    // Lowest index wins
    localparam int unsigned objMissile = 1;
    localparam int unsigned objMonster = 2;

    localparam int unsigned hitW = 2;
    localparam int unsigned hitMissile = 0;   // Missile on monster
    localparam int unsigned hitPlayer = 1;    // Monster on player

    localparam int unsigned scoreW = 8;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Default sizes and steps, in pixels
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int unsigned playerW = 4;
    localparam int unsigned playerH = 2;
    localparam int unsigned missileW = 1;
    localparam int unsigned missileH = 2;
    localparam int unsigned monsterW = 4;
    localparam int unsigned monsterH = 2;

    localparam int unsigned playerStepDef = 2;
    localparam int unsigned missileStepDef = 3;
    localparam int unsigned monsterStepDef = 1;

endpackage

`default_nettype wire

// File: source/hitDetection.sv
`timescale 1ns/10ps
`default_nettype none

module hitDetection #(
    parameter int unsigned objCount = 3
) (
    input  logic                      clk,
    input  logic                      arstN,
    pixelBus.sink                     pix,
    input  logic [objCount-1:0]       drawReq,
    output logic [gamePkg::hitW-1:0] hit
);
    import gamePkg::*;

    logic missileMonsterNow;
    logic monsterPlayerNow;
    logic missileMonsterQ;
    logic monsterPlayerQ;

    assign missileMonsterNow = drawReq[objMissile] & drawReq[objMonster];
    assign monsterPlayerNow = drawReq[objMonster] & drawReq[objPlayer];

    // Flags collect one frame; pixel (0, 0) already counts for the new one
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            missileMonsterQ <= 1'b0;
            monsterPlayerQ <= 1'b0;
        end else if (pix.startOfFrame) begin
            missileMonsterQ <= missileMonsterNow;
            monsterPlayerQ <= monsterPlayerNow;
        end else begin
            missileMonsterQ <= missileMonsterQ | missileMonsterNow;
            monsterPlayerQ <= monsterPlayerQ | monsterPlayerNow;
        end
    end

    always_comb begin
        hit = '0;
        if (pix.startOfFrame) begin   // Report window is the frame start cycle
            hit[hitMissile] = missileMonsterQ;
            hit[hitPlayer] = monsterPlayerQ;
        end
    end

endmodule

`default_nettype wire

// File: source/invadersTop.sv
`timescale 1ns/10ps
`default_nettype none

module invadersTop #(
    parameter int unsigned hActive = 32,
    parameter int unsigned vActive = 24,
    parameter int unsigned hTotal = 40,
    parameter int unsigned vTotal = 30,
    parameter int unsigned playerStep = gamePkg::playerStepDef,
    parameter int unsigned missileStep = gamePkg::missileStepDef,
    parameter int unsigned monsterStep = gamePkg::monsterStepDef,
    parameter int unsigned borderW = 1
) (
    input  logic                          clk,
    input  logic                          arstN,
    input  logic                          moveLeft,
    input  logic                          moveRight,
    input  logic                          fire,
    output logic [videoPkg::rgbW-1:0]    rgbOut,
    output logic                          pixelValid,
    output logic                          frameStart,
    output logic [gamePkg::scoreW-1:0]   score
);
    import videoPkg::*;
    import gamePkg::*;

    localparam int unsigned playerRow = vActive - borderW - playerH;   // Bottom band

    logic [pixelW-1:0] playerX;
    logic [pixelW-1:0] missileX;
    logic [pixelW-1:0] missileY;
    logic missileOn;
    logic [pixelW-1:0] monsterX;
    logic [pixelW-1:0] monsterY;
    logic [objCount-1:0] drawReq;
    logic [hitW-1:0] hit;

    pixelBus pix ();

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Raster and object sprites
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    rasterScan #(.hActive(hActive), .vActive(vActive), .hTotal(hTotal), .vTotal(vTotal))
        rasterInst (.clk(clk), .arstN(arstN), .pix(pix));

    rectSprite #(.width(playerW), .height(playerH)) playerSprite (
        .clk(clk), .arstN(arstN), .pix(pix),
        .posX(playerX), .posY(pixelW'(playerRow)), .show(1'b1),
        .draw(drawReq[objPlayer]));

    rectSprite #(.width(missileW), .height(missileH)) missileSprite (
        .clk(clk), .arstN(arstN), .pix(pix),
        .posX(missileX), .posY(missileY), .show(missileOn),
        .draw(drawReq[objMissile]));

    rectSprite #(.width(monsterW), .height(monsterH)) monsterSprite (
        .clk(clk), .arstN(arstN), .pix(pix),
        .posX(monsterX), .posY(monsterY), .show(1'b1),
        .draw(drawReq[objMonster]));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Game control, hits and video out
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    playerControl #(.hActive(hActive), .borderW(borderW), .playerRow(playerRow),
                    .playerStep(playerStep), .missileStep(missileStep))
        playerInst (.clk(clk), .arstN(arstN), .pix(pix),
                    .moveLeft(moveLeft), .moveRight(moveRight), .fire(fire), .hit(hit),
                    .playerX(playerX), .missileX(missileX), .missileY(missileY),
                    .missileOn(missileOn));

    monsterControl #(.hActive(hActive), .borderW(borderW), .monsterStep(monsterStep))
        monsterInst (.clk(clk), .arstN(arstN), .pix(pix), .hit(hit),
                     .monsterX(monsterX), .monsterY(monsterY), .score(score));

    hitDetection #(.objCount(objCount)) hitInst (
        .clk(clk), .arstN(arstN), .pix(pix), .drawReq(drawReq), .hit(hit));

    videoMixer #(.hActive(hActive), .vActive(vActive), .borderW(borderW)) mixerInst (
        .clk(clk), .arstN(arstN), .pix(pix), .drawReq(drawReq),
        .rgbOut(rgbOut), .pixelValid(pixelValid), .frameStart(frameStart));

endmodule

`default_nettype wire

// File: source/monsterControl.sv
`timescale 1ns/10ps
`default_nettype none

module monsterControl #(
    parameter int unsigned hActive = 32,
    parameter int unsigned borderW = 1,
    parameter int unsigned monsterStep = 1
) (
    input  logic                         clk,
    input  logic                         arstN,
    pixelBus.sink                        pix,
    input  logic [gamePkg::hitW-1:0]    hit,
    output logic [videoPkg::pixelW-1:0] monsterX,
    output logic [videoPkg::pixelW-1:0] monsterY,
    output logic [gamePkg::scoreW-1:0]  score
);
    import videoPkg::*;
    import gamePkg::*;

    localparam logic [pixelW-1:0] rowY = pixelW'(borderW + 2);
    localparam logic [pixelW-1:0] startX = pixelW'(hActive / 4);
    localparam logic [pixelW-1:0] step = pixelW'(monsterStep);
    localparam logic [pixelW-1:0] leftLimit = pixelW'(borderW + monsterStep);
    localparam logic [pixelW-1:0] maxX = pixelW'(hActive - borderW - monsterW);

    logic dirRight;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            monsterX <= startX;
            dirRight <= 1'b1;
            score <= '0;
        end else if (pix.startOfFrame) begin
            if (hit[hitMissile]) begin
                score <= score + 1'b1;
                monsterX <= startX;   // Respawn
                dirRight <= 1'b1;
            end else if (dirRight) begin
                if (monsterX + step > maxX) begin
                    dirRight <= 1'b0;
                    monsterX <= monsterX - step;
                end else begin
                    monsterX <= monsterX + step;
                end
            end else if (monsterX < leftLimit) begin
                dirRight <= 1'b1;
                monsterX <= monsterX + step;
            end else begin
                monsterX <= monsterX - step;
            end
        end
    end

    assign monsterY = rowY;   // Fixed row

endmodule

`default_nettype wire

// File: source/pixelBus.sv
`timescale 1ns/10ps
`default_nettype none

interface pixelBus;

    logic [videoPkg::pixelW-1:0] pixelX;
    logic [videoPkg::pixelW-1:0] pixelY;
    logic startOfFrame;   // Only at (0, 0)
    logic active;

    modport source (
        output pixelX, pixelY, startOfFrame, active
    );

    modport sink (
        input pixelX, pixelY, startOfFrame, active
    );

endinterface

`default_nettype wire

// File: source/playerControl.sv
`timescale 1ns/10ps
`default_nettype none

module playerControl #(
    parameter int unsigned hActive = 32,
    parameter int unsigned borderW = 1,
    parameter int unsigned playerRow = 21,
    parameter int unsigned playerStep = 2,
    parameter int unsigned missileStep = 3
) (
    input  logic                         clk,
    input  logic                         arstN,
    pixelBus.sink                        pix,
    input  logic                         moveLeft,
    input  logic                         moveRight,
    input  logic                         fire,
    input  logic [gamePkg::hitW-1:0]    hit,
    output logic [videoPkg::pixelW-1:0] playerX,
    output logic [videoPkg::pixelW-1:0] missileX,
    output logic [videoPkg::pixelW-1:0] missileY,
    output logic                         missileOn
);
    import videoPkg::*;
    import gamePkg::*;

    localparam logic [pixelW-1:0] minX = pixelW'(borderW);
    localparam logic [pixelW-1:0] maxX = pixelW'(hActive - borderW - playerW);
    localparam logic [pixelW-1:0] startX = pixelW'((hActive - playerW) / 2);
    localparam logic [pixelW-1:0] pStep = pixelW'(playerStep);
    localparam logic [pixelW-1:0] mStep = pixelW'(missileStep);
    localparam logic [pixelW-1:0] launchY = pixelW'(playerRow - missileH);
    localparam logic [pixelW-1:0] topLimit = pixelW'(borderW + missileStep);
    localparam logic [pixelW-1:0] centreOff = pixelW'((playerW - missileW) / 2);

    logic leftQ;
    logic rightQ;
    logic fireQ;
    logic [pixelW-1:0] playerNext;

    // Sticky strobes, consumed and reloaded at frame start
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            leftQ <= 1'b0;
            rightQ <= 1'b0;
            fireQ <= 1'b0;
        end else if (pix.startOfFrame) begin
            leftQ <= moveLeft;
            rightQ <= moveRight;
            fireQ <= fire;
        end else begin
            leftQ <= leftQ | moveLeft;
            rightQ <= rightQ | moveRight;
            fireQ <= fireQ | fire;
        end
    end

    always_comb begin
        playerNext = playerX;
        if (leftQ && !rightQ) begin
            playerNext = (playerX < minX + pStep) ? minX : playerX - pStep;
        end else if (rightQ && !leftQ) begin
            playerNext = (playerX + pStep > maxX) ? maxX : playerX + pStep;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            playerX <= startX;
            missileX <= '0;
            missileY <= '0;
            missileOn <= 1'b0;
        end else if (pix.startOfFrame) begin
            playerX <= playerNext;
            if (missileOn) begin
                if (hit[hitMissile] || (missileY < topLimit)) begin
                    missileOn <= 1'b0;   // Hit or leaving the field
                end else begin
                    missileY <= missileY - mStep;
                end
            end else if (fireQ) begin
                missileOn <= 1'b1;
                missileX <= playerNext + centreOff;
                missileY <= launchY;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/rasterScan.sv
`timescale 1ns/10ps
`default_nettype none

module rasterScan #(
    parameter int unsigned hActive = 32,
    parameter int unsigned vActive = 24,
    parameter int unsigned hTotal = 40,
    parameter int unsigned vTotal = 30
) (
    input  logic   clk,
    input  logic   arstN,
    pixelBus.source pix
);
    import videoPkg::*;

    localparam logic [pixelW-1:0] lastX = pixelW'(hTotal - 1);
    localparam logic [pixelW-1:0] lastY = pixelW'(vTotal - 1);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pix.pixelX <= '0;
            pix.pixelY <= '0;
        end else if (pix.pixelX == lastX) begin
            pix.pixelX <= '0;
            if (pix.pixelY == lastY) begin
                pix.pixelY <= '0;   // Wrap to next frame
            end else begin
                pix.pixelY <= pix.pixelY + 1'b1;
            end
        end else begin
            pix.pixelX <= pix.pixelX + 1'b1;
        end
    end

    assign pix.startOfFrame = (pix.pixelX == '0) && (pix.pixelY == '0);
    assign pix.active = (pix.pixelX < pixelW'(hActive)) && (pix.pixelY < pixelW'(vActive));

endmodule

`default_nettype wire

// File: source/rectSprite.sv
`timescale 1ns/10ps
`default_nettype none

module rectSprite #(
    parameter int unsigned width = 4,
    parameter int unsigned height = 2
) (
    input  logic                         clk,
    input  logic                         arstN,
    pixelBus.sink                        pix,
    input  logic [videoPkg::pixelW-1:0] posX,
    input  logic [videoPkg::pixelW-1:0] posY,
    input  logic                         show,
    output logic                         draw
);
    import videoPkg::*;

    logic [pixelW-1:0] rightQ;
    logic [pixelW-1:0] bottomQ;

    // Far edges kept in registers, so the compare path has no adder.
    // They trail a corner move by one clock, still on the top border row.
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rightQ <= '0;
            bottomQ <= '0;
        end else begin
            rightQ <= posX + pixelW'(width);
            bottomQ <= posY + pixelW'(height);
        end
    end

    assign draw = show && pix.active
                  && (pix.pixelX >= posX) && (pix.pixelX < rightQ)
                  && (pix.pixelY >= posY) && (pix.pixelY < bottomQ);

endmodule

`default_nettype wire

// File: source/videoMixer.sv
`timescale 1ns/10ps
`default_nettype none

module videoMixer #(
    parameter int unsigned hActive = 32,
    parameter int unsigned vActive = 24,
    parameter int unsigned borderW = 1
) (
    input  logic                          clk,
    input  logic                          arstN,
    pixelBus.sink                         pix,
    input  logic [gamePkg::objCount-1:0] drawReq,
    output logic [videoPkg::rgbW-1:0]    rgbOut,
    output logic                          pixelValid,
    output logic                          frameStart
);
    import videoPkg::*;
    import gamePkg::*;

    localparam logic [pixelW-1:0] edgeLo = pixelW'(borderW);
    localparam logic [pixelW-1:0] edgeRight = pixelW'(hActive - borderW);
    localparam logic [pixelW-1:0] edgeBottom = pixelW'(vActive - borderW);

    logic onBorder;
    logic [rgbW-1:0] pixelRgb;

    assign onBorder = (pix.pixelX < edgeLo) || (pix.pixelX >= edgeRight)
                      || (pix.pixelY < edgeLo) || (pix.pixelY >= edgeBottom);

    always_comb begin
        pixelRgb = onBorder ? borderColour : bgColour;
        for (int i = objCount - 1; i >= 0; i--) begin
            if (drawReq[i]) begin
                pixelRgb = objColour[i];   // Lower index overrides
            end
        end
        if (!pix.active) begin
            pixelRgb = '0;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rgbOut <= '0;
            pixelValid <= 1'b0;
            frameStart <= 1'b0;
        end else begin
            rgbOut <= pixelRgb;
            pixelValid <= pix.active;
            frameStart <= pix.startOfFrame;
        end
    end

endmodule

`default_nettype wire

// File: source/videoPkg.sv
`default_nettype none

package videoPkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Raster and colour widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int unsigned pixelW = 10;
    localparam int unsigned rgbW = 8;   // RRR GGG BB

    localparam logic [rgbW-1:0] bgColour = 8'h02;        // Dark blue
    localparam logic [rgbW-1:0] borderColour = 8'h92;    // Grey
    localparam logic [rgbW-1:0] playerColour = 8'h1C;    // Green
    localparam logic [rgbW-1:0] missileColour = 8'hFC;   // Yellow
    localparam logic [rgbW-1:0] monsterColour = 8'hE0;   // Red

    // Priority order: entry 0 is drawn on top of the others
    localparam logic [rgbW-1:0] objColour [0:2] = '{
        playerColour,
        missileColour,
        monsterColour
    };

endpackage

`default_nettype wire

// File: tests/invadersTb.sv
`timescale 1ns/10ps
`default_nettype none

module invadersTb;
    import videoPkg::*;
    import gamePkg::*;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Geometry and game rules of the default top level
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int hActive = 32;
    localparam int vActive = 24;
    localparam int hTotal = 40;
    localparam int vTotal = 30;
    localparam int borderW = 1;
    localparam int playerStep = 2;
    localparam int missileStep = 3;
    localparam int monsterStep = 1;
    localparam int playerRow = vActive - borderW - playerH;   // Bottom band
    localparam int playerStartX = (hActive - playerW) / 2;
    localparam int playerMaxX = hActive - borderW - playerW;
    localparam int monsterRow = borderW + 2;
    localparam int monsterStartX = hActive / 4;
    localparam int pixelCount = hActive * vActive;
    localparam int frameCycles = hTotal * vTotal;
    localparam int rowCount = 51;

    typedef struct packed {
        int left;
        int right;
        int fire;
        int score;   // Expected while this frame is shown
    } stimRow;

    // One row per frame, strobes act on the following frame
    localparam stimRow stimTable [rowCount] = '{
        '{1, 0, 1, 0}, '{1, 0, 1, 0}, '{1, 0, 0, 0}, '{1, 1, 0, 0}, '{1, 0, 0, 0},
        '{1, 0, 0, 0}, '{1, 0, 0, 0}, '{1, 0, 0, 0}, '{1, 1, 0, 0}, '{0, 1, 0, 0},
        '{0, 1, 0, 0}, '{0, 1, 0, 0}, '{0, 1, 0, 0}, '{0, 1, 0, 0}, '{0, 1, 0, 0},
        '{0, 1, 0, 0}, '{0, 1, 0, 0}, '{0, 1, 0, 0}, '{0, 1, 0, 0}, '{0, 1, 0, 0},
        '{0, 1, 0, 0}, '{0, 1, 0, 0}, '{0, 1, 0, 0}, '{0, 0, 0, 0}, '{1, 0, 0, 0},
        '{1, 0, 0, 0}, '{1, 0, 0, 0}, '{1, 0, 0, 0}, '{1, 0, 0, 0}, '{1, 0, 0, 0},
        '{1, 0, 0, 0}, '{1, 0, 0, 0}, '{1, 0, 0, 0}, '{1, 0, 0, 0}, '{1, 0, 0, 0},
        '{0, 0, 0, 0}, '{0, 0, 0, 0}, '{0, 0, 0, 0}, '{0, 0, 0, 0}, '{0, 0, 0, 0},
        '{0, 0, 0, 0}, '{0, 0, 0, 0}, '{0, 0, 1, 0}, '{0, 0, 0, 0}, '{0, 0, 0, 0},
        '{0, 0, 1, 0}, '{0, 0, 0, 0}, '{0, 0, 0, 0}, '{0, 0, 0, 0}, '{0, 0, 0, 1},
        '{0, 0, 0, 1}   // Monster back at its start after the hit
    };

    logic clk;
    logic arstN;
    logic moveLeft;
    logic moveRight;
    logic fire;
    logic [rgbW-1:0] rgbOut;
    logic pixelValid;
    logic frameStart;
    logic [scoreW-1:0] score;

    // Reference model state
    int playerX;
    int missileX;
    int missileY;
    int monsterX;
    logic missileOn;
    logic monsterRight;
    logic pendingHit;
    int lastLeft;
    int lastRight;
    int lastFire;
    logic [rgbW-1:0] expFrame [pixelCount];
    logic [rgbW-1:0] gotFrame [pixelCount];

    invadersTop dut (
        .clk(clk), .arstN(arstN), .moveLeft(moveLeft), .moveRight(moveRight), .fire(fire),
        .rgbOut(rgbOut), .pixelValid(pixelValid), .frameStart(frameStart), .score(score));

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic checkValue(input string what, input int got, input int expected);
        if (got != expected) begin
            abortRun($sformatf("ERR %0t: %s is 0x%0h, expected 0x%0h",
                               $time, what, got, expected));
        end
    endtask

    function automatic logic inRect(input int x, input int y, input int left, input int top,
                                    input int w, input int h);
        return (x >= left) && (x < left + w) && (y >= top) && (y < top + h);
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model, one step per frame start
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic stepModel();
        if (lastLeft != 0 && lastRight == 0) begin
            playerX = (playerX >= borderW + playerStep) ? playerX - playerStep : borderW;
        end else if (lastRight != 0 && lastLeft == 0) begin
            playerX = (playerX + playerStep <= playerMaxX) ? playerX + playerStep : playerMaxX;
        end
        if (missileOn) begin
            if (pendingHit || missileY < borderW + missileStep) begin
                missileOn = 1'b0;
            end else begin
                missileY = missileY - missileStep;
            end
        end else if (lastFire != 0) begin
            missileOn = 1'b1;   // Centred above the moved player
            missileX = playerX + (playerW - missileW) / 2;
            missileY = playerRow - missileH;
        end
        if (pendingHit) begin
            monsterX = monsterStartX;
            monsterRight = 1'b1;
        end else if (monsterRight) begin
            if (monsterX + monsterStep + monsterW > hActive - borderW) begin
                monsterRight = 1'b0;
                monsterX = monsterX - monsterStep;
            end else begin
                monsterX = monsterX + monsterStep;
            end
        end else if (monsterX < borderW + monsterStep) begin
            monsterRight = 1'b1;
            monsterX = monsterX + monsterStep;
        end else begin
            monsterX = monsterX - monsterStep;
        end
    endtask

    task automatic renderFrame();
        int x;
        int y;
        logic onPlayer;
        logic onMissile;
        logic onMonster;
        logic [rgbW-1:0] colour;
        pendingHit = 1'b0;
        for (int i = 0; i < pixelCount; i++) begin
            x = i % hActive;
            y = i / hActive;
            onPlayer = inRect(x, y, playerX, playerRow, playerW, playerH);
            onMissile = missileOn && inRect(x, y, missileX, missileY, missileW, missileH);
            onMonster = inRect(x, y, monsterX, monsterRow, monsterW, monsterH);
            if (x < borderW || x >= hActive - borderW
                    || y < borderW || y >= vActive - borderW) begin
                colour = borderColour;
            end else begin
                colour = bgColour;
            end
            if (onMonster) colour = monsterColour;
            if (onMissile) colour = missileColour;
            if (onPlayer) colour = playerColour;   // Player is on top
            expFrame[i] = colour;
            if (onMissile && onMonster) pendingHit = 1'b1;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // DUT side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic waitFrameStart();
        int cycles;
        cycles = 0;
        while (!frameStart) begin
            @(negedge clk);
            cycles++;
            if (cycles > 2 * frameCycles) begin
                abortRun("No frameStart pulse was seen within two frame times");
            end
        end
    endtask

    task automatic captureFrame(input int row);
        int captured;
        int cycles;
        logic strobeNow;
        captured = 0;
        cycles = 0;
        while (captured < pixelCount) begin
            if (pixelValid) begin
                gotFrame[captured] = rgbOut;
                captured++;
            end
            strobeNow = (cycles == 40) || (cycles == 400);   // Two pulses in one frame
            @(posedge clk);
            moveLeft <= strobeNow && (stimTable[row].left != 0);
            moveRight <= strobeNow && (stimTable[row].right != 0);
            fire <= strobeNow && (stimTable[row].fire != 0);
            @(negedge clk);
            cycles++;
            if (cycles > frameCycles) begin
                abortRun($sformatf("Frame %0d gave only %0d valid pixels in one frame time",
                                   row, captured));
            end
        end
    endtask

    initial begin
        arstN = 1'b0;
        moveLeft = 1'b0;
        moveRight = 1'b0;
        fire = 1'b0;
        playerX = playerStartX;
        missileX = 0;
        missileY = 0;
        missileOn = 1'b0;
        monsterX = monsterStartX;
        monsterRight = 1'b1;
        pendingHit = 1'b0;
        lastLeft = 0;
        lastRight = 0;
        lastFire = 0;

        repeat (4) @(posedge clk);
        arstN <= 1'b1;
        @(negedge clk);
        checkValue("pixelValid after reset", int'(pixelValid), 0);
        checkValue("frameStart after reset", int'(frameStart), 0);
        checkValue("score after reset", int'(score), 0);

        for (int row = 0; row < rowCount; row++) begin
            waitFrameStart();
            stepModel();
            renderFrame();
            captureFrame(row);
            for (int i = 0; i < pixelCount; i++) begin
                checkValue($sformatf("frame %0d pixel (%0d, %0d)", row, i % hActive, i / hActive),
                           int'(gotFrame[i]), int'(expFrame[i]));
            end
            checkValue($sformatf("score in frame %0d", row), int'(score), stimTable[row].score);
            lastLeft = stimTable[row].left;
            lastRight = stimTable[row].right;
            lastFire = stimTable[row].fire;
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire
